/* tb.f */
aes_pkg.sv
aes_key_expansion.sv
aes_state_datapath.sv
aes_dec_control.sv
aes_decrypt.sv
tb_aes_decrypt.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        ?= tb_aes_decrypt
FILELIST   ?= tb.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

# The log decides the result, since tee hides the simulator's exit status.
run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "TEST PASS" $(LOG); then echo "Simulation ended without a result"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb_aes_decrypt.sv */
// AES-128 decryption testbench
`timescale 1ns/10ps

module tb_aes_decrypt;

	localparam int clk_period   = 40;
	localparam int reset_cycles = 16;
	localparam int num_rows     = 6;
	localparam int done_latency = 51; // Edges from sampled start to done.
	localparam int max_wait     = done_latency + 8;
	localparam int intrude_edge = 5;  // Falls inside key expansion.
	localparam int reset_edge   = 20; // Falls inside the round loop.
	localparam int reset_hold   = 3;
	localparam int watchdog_cycles = (num_rows + 2) * (done_latency + 8 + 4);

	logic         clk;
	logic         rst_n;
	logic         start;
	logic [127:0] key;
	logic [127:0] msg_enc;
	logic         done;
	logic [127:0] msg_dec;

	logic [127:0] vec_key [0:num_rows-1];
	logic [127:0] vec_enc [0:num_rows-1];
	logic [127:0] vec_dec [0:num_rows-1];
	logic [7:0]   lfsr;

	aes_decrypt aes_decrypt_inst (
		.clk     (clk),
		.rst_n   (rst_n),
		.start   (start),
		.key     (key),
		.msg_enc (msg_enc),
		.done    (done),
		.msg_dec (msg_dec)
	);

	always #(clk_period / 2) clk = ~clk;

	task automatic stop_run(input string reason);
		$display("%s", reason);
		$display("TEST FAIL");
		$fatal(1, "Simulation stopped on the first error.");
	endtask

	task automatic check_value(input string name, input logic [127:0] got,
			input logic [127:0] expected);
		if (got !== expected)
			stop_run($sformatf("FAILED at %0d ns: %s is %h, expected %h",
				$time, name, got, expected));
	endtask

	function automatic logic [7:0] lfsr_step(input logic [7:0] s);
		return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]}; // Taps 8, 6, 5, 4.
	endfunction

	// Three LFSR bits give an idle gap of 0 to 7 cycles.
	task automatic next_gap(output int gap);
		gap = 0;
		repeat (3) begin
			lfsr = lfsr_step(lfsr);
			gap = (gap << 1) | int'(lfsr[0]);
		end
	endtask

	task automatic run_block(input int row, input bit intrude);
		int edges;
		int gap;
		@(posedge clk);
		#2;
		key = vec_key[row];
		msg_enc = vec_enc[row];
		start = 1'b1;
		@(posedge clk); // DUT samples start here.
		#2;
		start = 1'b0;
		edges = 0;
		forever begin
			@(posedge clk);
			#1;
			edges++;
			if (done === 1'b1)
				break;
			if (edges >= max_wait)
				stop_run($sformatf("done did not pulse within %0d cycles of start", max_wait));
			#1;
			if (intrude && edges == intrude_edge) begin
				start = 1'b1; // Busy core must ignore this.
				key = ~vec_key[row];
				msg_enc = ~vec_enc[row];
			end else begin
				start = 1'b0;
			end
		end
		check_value("done latency", 128'(edges), 128'(done_latency));
		check_value("msg_dec", msg_dec, vec_dec[row]);
		next_gap(gap);
		repeat (gap + 1) begin
			@(posedge clk);
			#1;
			check_value("done", 128'(done), 128'(0)); // One-cycle pulse.
			check_value("msg_dec", msg_dec, vec_dec[row]);
		end
	endtask

	task automatic reset_mid_run(input int row);
		@(posedge clk);
		#2;
		key = vec_key[row];
		msg_enc = vec_enc[row];
		start = 1'b1;
		@(posedge clk);
		#2;
		start = 1'b0;
		repeat (reset_edge) @(posedge clk);
		#2;
		rst_n = 1'b0;
		#1;
		check_value("done", 128'(done), 128'(0));
		check_value("msg_dec", msg_dec, 128'(0)); // Asynchronous clear.
		repeat (reset_hold) @(posedge clk);
		#2;
		rst_n = 1'b1;
		repeat (done_latency - reset_edge - reset_hold) begin
			@(posedge clk);
			#1;
			check_value("done", 128'(done), 128'(0)); // Aborted run never finishes.
		end
	endtask

	initial begin
		#(watchdog_cycles * clk_period);
		stop_run("Watchdog expired before the tests finished");
	end

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		start = 1'b0;
		key = '0;
		msg_enc = '0;
		lfsr = 8'd82;
		vec_key = '{
			128'h2b7e151628aed2a6abf7158809cf4f3c, 128'h2b7e151628aed2a6abf7158809cf4f3c,
			128'h2b7e151628aed2a6abf7158809cf4f3c, 128'h2b7e151628aed2a6abf7158809cf4f3c,
			128'h2b7e151628aed2a6abf7158809cf4f3c, 128'h00000000000000000000000000000000
		};
		vec_enc = '{
			128'h3925841d02dc09fbdc118597196a0b32, 128'h3ad77bb40d7a3660a89ecaf32466ef97,
			128'hf5d3d58503b9699de785895a96fdbaaf, 128'h43b1cd7f598ece23881b00e3ed030688,
			128'h7b0c785e27e8ad3f8223207104725dd4, 128'h66e94bd4ef8a2c3b884cfa59ca342b2e
		};
		vec_dec = '{
			128'h3243f6a8885a308d313198a2e0370734, 128'h6bc1bee22e409f96e93d7e117393172a,
			128'hae2d8a571e03ac9c9eb76fac45af8e51, 128'h30c81c46a35ce411e5fbc1191a0a52ef,
			128'hf69f2445df4f9b17ad2b417be66c3710, 128'h00000000000000000000000000000000
		};
		repeat (reset_cycles) @(posedge clk);
		#2;
		rst_n = 1'b1;
		for (int i = 0; i < num_rows; i++)
			run_block(i, i == 2); // Row 2 also gets a stray start.
		reset_mid_run(0);
		run_block(3, 1'b0); // Fresh run after the reset.
		$display("TEST PASS");
		$finish;
	end

endmodule

/* aes_decrypt.sv */
// AES-128 decryption core
`timescale 1ns/10ps

module aes_decrypt (
	input  logic         clk,
	input  logic         rst_n,
	input  logic         start,
	input  logic [127:0] key,
	input  logic [127:0] msg_enc,
	output logic         done,
	output logic [127:0] msg_dec
);
	import aes_pkg::*;

	logic       key_start;
	logic       key_ready;
	logic       load_msg;
	logic       step_en;
	dec_step_t  step_sel;
	round_idx_t round_idx;
	aes_block_t round_key;

	aes_dec_control aes_dec_control_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.start     (start),
		.key_ready (key_ready),
		.key_start (key_start),
		.load_msg  (load_msg),
		.step_en   (step_en),
		.step_sel  (step_sel),
		.round_idx (round_idx),
		.done      (done)
	);

	aes_key_expansion aes_key_expansion_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.key_start (key_start),
		.key       (key),
		.round_idx (round_idx),
		.key_ready (key_ready),
		.round_key (round_key)
	);

	aes_state_datapath aes_state_datapath_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.msg_enc   (msg_enc),
		.load_msg  (load_msg),
		.step_en   (step_en),
		.step_sel  (step_sel),
		.round_key (round_key),
		.state     (msg_dec) // Plaintext once done pulses.
	);

endmodule

/* aes_dec_control.sv */
// AES decryption sequencer
`timescale 1ns/10ps

module aes_dec_control (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                start,
	input  logic                key_ready,
	output logic                key_start,
	output logic                load_msg,
	output logic                step_en,
	output aes_pkg::dec_step_t  step_sel,
	output aes_pkg::round_idx_t round_idx,
	output logic                done
);
	import aes_pkg::*;

	localparam logic [2:0] st_idle     = 3'd0;
	localparam logic [2:0] st_expand   = 3'd1;
	localparam logic [2:0] st_init_add = 3'd2;
	localparam logic [2:0] st_round    = 3'd3;
	localparam logic [2:0] st_final    = 3'd4;

	logic [2:0] fsm;
	logic [1:0] stp; // Step now issued within the round.

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			fsm <= st_idle;
			stp <= 2'd0;
			key_start <= 1'b0;
			load_msg <= 1'b0;
			step_en <= 1'b0;
			step_sel <= step_ark;
			round_idx <= 4'd0;
			done <= 1'b0;
		end else begin
			key_start <= 1'b0; // Strobes last one cycle.
			load_msg <= 1'b0;
			done <= 1'b0;
			case (fsm)
				st_idle: begin
					if (start) begin
						key_start <= 1'b1;
						load_msg <= 1'b1;
						fsm <= st_expand;
					end
				end
				st_expand: begin
					// key_ready may still be high from the previous block.
					if (key_ready && !key_start) begin
						step_en <= 1'b1;
						step_sel <= step_ark;
						round_idx <= num_rounds;
						fsm <= st_init_add;
					end
				end
				st_init_add: begin
					step_sel <= step_isr;
					round_idx <= round_idx - 4'd1;
					stp <= 2'd0;
					fsm <= st_round;
				end
				st_round: begin
					case (stp)
						2'd0: step_sel <= step_isb;
						2'd1: step_sel <= step_ark;
						2'd2: step_sel <= step_imc;
						default: begin
							step_sel <= step_isr; // Next round begins.
							round_idx <= round_idx - 4'd1;
							if (round_idx == 4'd1)
								fsm <= st_final; // Last round has no mix columns.
						end
					endcase
					stp <= stp + 2'd1;
				end
				st_final: begin
					stp <= stp + 2'd1;
					if (stp == 2'd0) begin
						step_sel <= step_isb;
					end else if (stp == 2'd1) begin
						step_sel <= step_ark; // Round key 0.
					end else begin
						step_en <= 1'b0;
						done <= 1'b1;
						fsm <= st_idle;
					end
				end
				default: fsm <= st_idle;
			endcase
		end
	end

	a_done_no_step: assert property (@(posedge clk) disable iff (!rst_n) !(done && step_en));
	a_idx_range: assert property (@(posedge clk) disable iff (!rst_n) round_idx <= num_rounds);

endmodule

/* aes_state_datapath.sv */
// AES inverse round datapath
`timescale 1ns/10ps

module aes_state_datapath (
	input  logic                clk,
	input  logic                rst_n,
	input  logic [127:0]        msg_enc,
	input  logic                load_msg,
	input  logic                step_en,
	input  aes_pkg::dec_step_t  step_sel,
	input  aes_pkg::aes_block_t round_key,
	output aes_pkg::aes_block_t state
);
	import aes_pkg::*;

	aes_block_t isr_res;
	aes_block_t isb_res;
	aes_block_t imc_res;
	aes_block_t ark_res;
	aes_block_t nxt;

	function automatic logic [31:0] inv_mix_col(input logic [31:0] c);
		logic [7:0] a0, a1, a2, a3;
		a0 = c[31:24]; // Top byte of the column.
		a1 = c[23:16];
		a2 = c[15:8];
		a3 = c[7:0];
		return {gf_mul(a0, 8'h0e) ^ gf_mul(a1, 8'h0b) ^ gf_mul(a2, 8'h0d) ^ gf_mul(a3, 8'h09),
			gf_mul(a0, 8'h09) ^ gf_mul(a1, 8'h0e) ^ gf_mul(a2, 8'h0b) ^ gf_mul(a3, 8'h0d),
			gf_mul(a0, 8'h0d) ^ gf_mul(a1, 8'h09) ^ gf_mul(a2, 8'h0e) ^ gf_mul(a3, 8'h0b),
			gf_mul(a0, 8'h0b) ^ gf_mul(a1, 8'h0d) ^ gf_mul(a2, 8'h09) ^ gf_mul(a3, 8'h0e)};
	endfunction

	// All four candidates are formed every cycle.
	always_comb begin
		for (int c = 0; c < 4; c++) begin
			for (int r = 0; r < 4; r++)
				isr_res.bytes[15 - (r + 4 * c)] = state.bytes[15 - (r + 4 * ((c + 4 - r) % 4))];
		end
		for (int i = 0; i < 16; i++)
			isb_res.bytes[i] = inv_sbox(state.bytes[i]);
		for (int k = 0; k < 4; k++)
			imc_res.cols[k] = inv_mix_col(state.cols[k]);
		ark_res = state ^ round_key;
		case (step_sel)
			step_isr: nxt = isr_res;
			step_isb: nxt = isb_res;
			step_imc: nxt = imc_res;
			default:  nxt = ark_res;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			state <= '0;
		else if (load_msg)
			state <= msg_enc; // Ciphertext enters the state.
		else if (step_en)
			state <= nxt;
	end

	a_load_vs_step: assert property (@(posedge clk) disable iff (!rst_n) !(load_msg && step_en));

endmodule

/* aes_key_expansion.sv */
// AES-128 key schedule
`timescale 1ns/10ps

module aes_key_expansion (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                key_start,
	input  logic [127:0]        key,
	input  aes_pkg::round_idx_t round_idx,
	output logic                key_ready,
	output aes_pkg::aes_block_t round_key
);
	import aes_pkg::*;

	aes_block_t rk [0:10]; // Round keys 0 to 10.
	aes_block_t src;
	aes_block_t nxt;
	round_idx_t cnt;       // Index of the next key to derive.
	round_idx_t wr_idx;
	logic       busy;
	logic [31:0] t;

	// Derive one round key from the previous one.
	always_comb begin
		if (key_start) begin
			src = key;
			wr_idx = 4'd1;
		end else begin
			src = rk[cnt - 4'd1];
			wr_idx = cnt;
		end
		t = {sbox(src.cols[0][23:16]), sbox(src.cols[0][15:8]),
			sbox(src.cols[0][7:0]), sbox(src.cols[0][31:24])}; // RotWord then SubWord.
		t[31:24] = t[31:24] ^ rcon(wr_idx);
		nxt.cols[3] = src.cols[3] ^ t;
		nxt.cols[2] = src.cols[2] ^ nxt.cols[3];
		nxt.cols[1] = src.cols[1] ^ nxt.cols[2];
		nxt.cols[0] = src.cols[0] ^ nxt.cols[1];
	end

	always_ff @(posedge clk) begin
		if (key_start)
			rk[0] <= key; // Cipher key is round key 0.
		if (key_start || busy)
			rk[wr_idx] <= nxt;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			cnt <= 4'd1;
			key_ready <= 1'b0;
		end else if (key_start) begin
			busy <= 1'b1;
			cnt <= 4'd2;
			key_ready <= 1'b0;
		end else if (busy) begin
			if (cnt == num_rounds) begin
				busy <= 1'b0;
				key_ready <= 1'b1; // All eleven keys stored.
			end else begin
				cnt <= cnt + 4'd1;
			end
		end
	end

	assign round_key = rk[round_idx];

	// A restart would corrupt the keys being derived.
	a_no_restart: assert property (@(posedge clk) disable iff (!rst_n) key_start |-> !busy);

endmodule

/* aes_pkg.sv */
// AES-128 shared definitions
package aes_pkg;

	// One 128-bit block seen as bytes or as columns.
	typedef union packed {
		logic [15:0][7:0] bytes; // bytes[15] holds state byte 0.
		logic [3:0][31:0] cols;  // cols[3] holds column 0.
	} aes_block_t;

	typedef enum logic [1:0] {
		step_ark, // Add round key.
		step_isr, // Inverse shift rows.
		step_isb, // Inverse sub bytes.
		step_imc  // Inverse mix columns.
	} dec_step_t;

	typedef logic [3:0] round_idx_t;

	localparam round_idx_t num_rounds = 4'd10;

	function automatic logic [7:0] xtime(input logic [7:0] a);
		return {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00); // Multiply by x mod the AES polynomial.
	endfunction

	function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
		logic [7:0] acc;
		logic [7:0] x;
		acc = 8'h00;
		x = a;
		for (int i = 0; i < 8; i++) begin
			if (b[i])
				acc = acc ^ x;
			x = xtime(x);
		end
		return acc;
	endfunction

	// Inverse in GF(2^8) as a^254, which maps zero to zero.
	function automatic logic [7:0] gf_inv(input logic [7:0] a);
		logic [7:0] sq;
		logic [7:0] r;
		sq = a;
		r = 8'h01;
		for (int i = 1; i < 8; i++) begin
			sq = gf_mul(sq, sq); // a^(2^i).
			r = gf_mul(r, sq);
		end
		return r;
	endfunction

	function automatic logic [7:0] rotl8(input logic [7:0] a, input int unsigned n);
		return (a << n) | (a >> (8 - n));
	endfunction

	function automatic logic [7:0] sbox(input logic [7:0] a);
		logic [7:0] b;
		b = gf_inv(a);
		return b ^ rotl8(b, 1) ^ rotl8(b, 2) ^ rotl8(b, 3) ^ rotl8(b, 4) ^ 8'h63;
	endfunction

	function automatic logic [7:0] inv_sbox(input logic [7:0] a);
		logic [7:0] b;
		b = rotl8(a, 1) ^ rotl8(a, 3) ^ rotl8(a, 6) ^ 8'h05; // Undo the affine map first.
		return gf_inv(b);
	endfunction

	function automatic logic [7:0] rcon(input round_idx_t r);
		case (r)
			4'd1:    return 8'h01;
			4'd2:    return 8'h02;
			4'd3:    return 8'h04;
			4'd4:    return 8'h08;
			4'd5:    return 8'h10;
			4'd6:    return 8'h20;
			4'd7:    return 8'h40;
			4'd8:    return 8'h80;
			4'd9:    return 8'h1b;
			4'd10:   return 8'h36;
			default: return 8'h00;
		endcase
	endfunction

endpackage
